/* verilog/irq_sleep_macros.svh */
/* Interrupt and sleep controller constants
   Widths, implemented interrupt lines, sleep instruction encodings and dwell */
`ifndef IRQ_SLEEP_MACROS_SVH
`define IRQ_SLEEP_MACROS_SVH

// --------------------
// Interrupt lines
// --------------------
`define IRQ_NUM 32
`define IRQ_ID_W 5

// Lines 31..16, 11, 7 and 3 are implemented, the rest are reserved
`define IRQ_VALID_MASK 32'hffff_0888

// --------------------
// Instruction encodings
// --------------------
`define INSTR_W 32
`define WFI_FUNCT12 12'h105
`define WFE_FUNCT12 12'h8c0
`define OPC_SYSTEM 7'b1110011

// --------------------
// Sleep entry
// --------------------
// Cycles a sleep instruction sits in writeback before sleep may start
`define SLEEP_DWELL 2

// Outstanding bus transaction counter width
`define OUTST_W 4

`endif

/* verilog/irq_sleep_pkg.sv */
/* Shared types for the interrupt and sleep controller
   Writeback instruction word views and privilege levels */
`default_nettype none

`include "irq_sleep_macros.svh"

package irq_sleep_pkg;

  // --------------------
  // Writeback instruction word
  // --------------------
  // SYSTEM-format field layout, MSB first
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } system_fields_t;

  // Same word seen either raw or split into SYSTEM fields
  typedef union packed {
    logic [`INSTR_W-1:0] raw;
    system_fields_t      sys;
  } instr_word_u;

  // --------------------
  // Privilege level
  // --------------------
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

endpackage

`default_nettype wire

/* verilog/irq_arbiter.sv */
/* Interrupt arbiter
   Registers pending lines, picks the winner and issues a one-cycle acknowledge */
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_macros.svh"

module irq_arbiter
  import irq_sleep_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic [`IRQ_NUM-1:0]  irq_i,
  input  wire logic [`IRQ_NUM-1:0]  mie_i,
  input  wire logic                 mstatus_mie_i,
  input  wire priv_lvl_e            priv_lvl_i,
  output logic      [`IRQ_NUM-1:0]  mip_o,
  output logic                      pending_o,
  output logic                      irq_ack_o,
  output logic      [`IRQ_ID_W-1:0] irq_id_o
);

  logic [`IRQ_NUM-1:0]  mip_q;
  logic [`IRQ_NUM-1:0]  pend_en;
  logic [`IRQ_ID_W-1:0] winner_id;
  logic                 global_en;
  logic                 take;
  logic                 ack_q;
  logic [`IRQ_ID_W-1:0] id_q;

  // --------------------
  // Pending register
  // --------------------
  // Reserved lines never show up in mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_VALID_MASK;
    end
  end

  assign mip_o     = mip_q;
  assign pend_en   = mip_q & mie_i;
  assign pending_o = |pend_en;

  // --------------------
  // Priority
  // --------------------
  // Lowest priority first, later hits override earlier ones
  // Order from the top: 31..16, then 11, then 3, then 7
  always_comb begin
    winner_id = '0;
    if (pend_en[7]) begin
      winner_id = `IRQ_ID_W'd7;
    end
    if (pend_en[3]) begin
      winner_id = `IRQ_ID_W'd3;
    end
    if (pend_en[11]) begin
      winner_id = `IRQ_ID_W'd11;
    end
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_en[i]) begin
        winner_id = i[`IRQ_ID_W-1:0];
      end
    end
  end

  // --------------------
  // Global enable and acknowledge
  // --------------------
  // M-mode needs MSTATUS.MIE, U-mode takes any enabled pending line
  assign global_en = ((priv_lvl_i == PRIV_M) && mstatus_mie_i) ||
                     ((priv_lvl_i == PRIV_U) && pending_o);

  // No back-to-back acks, the core needs a cycle to update its state
  assign take = pending_o && global_en && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q <= winner_id;
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

endmodule

`default_nettype wire

/* verilog/bus_idle_tracker.sv */
/* Bus idle tracker
   Counts outstanding instruction-side and data-side transactions */
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_macros.svh"

module bus_idle_tracker (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic ireq_i,
  input  wire logic ignt_i,
  input  wire logic irvalid_i,
  input  wire logic dreq_i,
  input  wire logic dgnt_i,
  input  wire logic drvalid_i,
  output logic      bus_idle_o
);

  // Index 0 is the instruction side, index 1 the data side
  localparam int unsigned NUM_SIDES = 2;

  logic [NUM_SIDES-1:0] start;
  logic [NUM_SIDES-1:0] resp;
  logic [`OUTST_W-1:0]  cnt_q [NUM_SIDES];

  // --------------------
  // Handshake events
  // --------------------
  // Address phase accepted when req and gnt meet
  assign start[0] = ireq_i && ignt_i;
  assign start[1] = dreq_i && dgnt_i;

  // Response phase
  assign resp[0] = irvalid_i;
  assign resp[1] = drvalid_i;

  // --------------------
  // Outstanding counters
  // --------------------
  // A start and a response in the same cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SIDES; s++) begin
        cnt_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < NUM_SIDES; s++) begin
        if (start[s] && !resp[s]) begin
          cnt_q[s] <= cnt_q[s] + 1'b1;
        end else if (!start[s] && resp[s]) begin
          cnt_q[s] <= cnt_q[s] - 1'b1;
        end
      end
    end
  end

  // Idle only when nothing is in flight on either side
  assign bus_idle_o = (cnt_q[0] == '0) && (cnt_q[1] == '0);

endmodule

`default_nettype wire

/* verilog/wfi_decode_stage.sv */
/* WFI and WFE qualification in writeback
   Decodes the sleep instructions and counts the dwell before sleep */
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_macros.svh"

module wfi_decode_stage
  import irq_sleep_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        wb_valid_i,
  input  wire instr_word_u wb_instr_i,
  input  wire logic        wb_err_i,
  input  wire logic        wb_kill_i,
  input  wire priv_lvl_e   priv_lvl_i,
  input  wire logic        mstatus_tw_i,
  output logic             in_wb_o,
  output logic             is_wfe_o,
  output logic             dwell_done_o
);

  localparam int unsigned DWELL_W = $clog2(`SLEEP_DWELL + 1);

  logic               sys_plain;
  logic               is_wfi;
  logic               is_wfe;
  logic               invalid;
  logic               qualified;
  logic [DWELL_W-1:0] dwell_q;

  // --------------------
  // Decode
  // --------------------
  // Both encodings use rs1, rd and funct3 all zero
  assign sys_plain = (wb_instr_i.sys.opcode == `OPC_SYSTEM) &&
                     (wb_instr_i.sys.funct3 == 3'b000) &&
                     (wb_instr_i.sys.rs1 == 5'd0) &&
                     (wb_instr_i.sys.rd == 5'd0);

  assign is_wfi = sys_plain && (wb_instr_i.sys.funct12 == `WFI_FUNCT12);
  assign is_wfe = sys_plain && (wb_instr_i.sys.funct12 == `WFE_FUNCT12);

  // Timeout-wait traps the instruction in U-mode instead of sleeping
  assign invalid = !wb_valid_i || wb_err_i || wb_kill_i ||
                   ((priv_lvl_i == PRIV_U) && mstatus_tw_i);

  assign qualified = (is_wfi || is_wfe) && !invalid;

  // --------------------
  // Dwell counter
  // --------------------
  // Saturates at the dwell length, restarts when the word drops out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dwell_q <= '0;
    end else if (!qualified) begin
      dwell_q <= '0;
    end else if (dwell_q != DWELL_W'(`SLEEP_DWELL)) begin
      dwell_q <= dwell_q + 1'b1;
    end
  end

  assign in_wb_o      = qualified;
  assign is_wfe_o     = qualified && is_wfe;
  assign dwell_done_o = qualified && (dwell_q == DWELL_W'(`SLEEP_DWELL));

endmodule

`default_nettype wire

/* verilog/sleep_ctrl.sv */
/* Sleep control
   Drives core sleep, handles wakeup and retires the sleeping instruction */
`timescale 1ns/1ps
`default_nettype none

module sleep_ctrl (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic in_wb_i,
  input  wire logic is_wfe_i,
  input  wire logic dwell_done_i,
  input  wire logic bus_idle_i,
  input  wire logic wbuf_empty_i,
  input  wire logic pending_i,
  input  wire logic debug_req_i,
  input  wire logic nmi_i,
  input  wire logic wu_wfe_i,
  output logic      core_sleep_o,
  output logic      retire_o
);

  logic wake;
  logic blocked;
  logic sleep_q;

  // --------------------
  // Wake and block conditions
  // --------------------
  // The WFE wakeup line only counts for a WFE, a WFI ignores it
  assign wake = pending_i || debug_req_i || nmi_i || (is_wfe_i && wu_wfe_i);

  // Anything still in flight keeps the core awake
  assign blocked = !bus_idle_i || !wbuf_empty_i;

  // --------------------
  // Core sleep register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else if (wake || blocked || !in_wb_i) begin
      sleep_q <= 1'b0;
    end else if (dwell_done_i) begin
      sleep_q <= 1'b1;
    end
  end

  assign core_sleep_o = sleep_q;

  // Sleeping instruction completes in the cycle the wake event shows up
  assign retire_o = in_wb_i && wake;

endmodule

`default_nettype wire

/* verilog/irq_sleep_top.sv */
/* Interrupt and sleep controller top level
   Connects the arbiter, bus tracker, sleep decode and sleep control */
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_macros.svh"

module irq_sleep_top
  import irq_sleep_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Interrupts and CSR state
  input  wire logic [`IRQ_NUM-1:0]  irq_i,
  input  wire logic [`IRQ_NUM-1:0]  mie_i,
  input  wire logic                 mstatus_mie_i,
  input  wire logic                 mstatus_tw_i,
  input  wire priv_lvl_e            priv_lvl_i,
  output logic      [`IRQ_NUM-1:0]  mip_o,
  output logic                      irq_ack_o,
  output logic      [`IRQ_ID_W-1:0] irq_id_o,
  // Writeback stage
  input  wire logic                 wb_valid_i,
  input  wire instr_word_u          wb_instr_i,
  input  wire logic                 wb_err_i,
  input  wire logic                 wb_kill_i,
  // Bus handshakes
  input  wire logic                 ireq_i,
  input  wire logic                 ignt_i,
  input  wire logic                 irvalid_i,
  input  wire logic                 dreq_i,
  input  wire logic                 dgnt_i,
  input  wire logic                 drvalid_i,
  input  wire logic                 wbuf_empty_i,
  // Wake sources and sleep status
  input  wire logic                 debug_req_i,
  input  wire logic                 nmi_i,
  input  wire logic                 wu_wfe_i,
  output logic                      core_sleep_o,
  output logic                      retire_o
);

  logic pending;
  logic in_wb;
  logic is_wfe;
  logic dwell_done;
  logic bus_idle;

  irq_arbiter u_irq_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .mip_o         (mip_o),
    .pending_o     (pending),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  bus_idle_tracker u_bus_idle_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ireq_i     (ireq_i),
    .ignt_i     (ignt_i),
    .irvalid_i  (irvalid_i),
    .dreq_i     (dreq_i),
    .dgnt_i     (dgnt_i),
    .drvalid_i  (drvalid_i),
    .bus_idle_o (bus_idle)
  );

  wfi_decode_stage u_wfi_decode_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_valid_i   (wb_valid_i),
    .wb_instr_i   (wb_instr_i),
    .wb_err_i     (wb_err_i),
    .wb_kill_i    (wb_kill_i),
    .priv_lvl_i   (priv_lvl_i),
    .mstatus_tw_i (mstatus_tw_i),
    .in_wb_o      (in_wb),
    .is_wfe_o     (is_wfe),
    .dwell_done_o (dwell_done)
  );

  sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_wb_i      (in_wb),
    .is_wfe_i     (is_wfe),
    .dwell_done_i (dwell_done),
    .bus_idle_i   (bus_idle),
    .wbuf_empty_i (wbuf_empty_i),
    .pending_i    (pending),
    .debug_req_i  (debug_req_i),
    .nmi_i        (nmi_i),
    .wu_wfe_i     (wu_wfe_i),
    .core_sleep_o (core_sleep_o),
    .retire_o     (retire_o)
  );

endmodule

`default_nettype wire

/* test/tb_irq_sleep.sv */
/* Testbench for the interrupt and sleep controller
   Random interrupt traffic against a reference model and directed sleep and wake cases */
`timescale 1ns/1ps
`default_nettype none

`include "irq_sleep_macros.svh"

module tb_irq_sleep
  import irq_sleep_pkg::*;
();

  localparam int RAND_CYCLES  = 250;
  localparam int SLEEP_CYCLES = 250;
  // Three random phases plus the directed sleep cases with a wide margin
  localparam int MAX_CYCLES   = 4 * (3 * RAND_CYCLES + SLEEP_CYCLES);

  logic                 clk_i;
  logic                 rst_ni;
  logic [`IRQ_NUM-1:0]  irq_i;
  logic [`IRQ_NUM-1:0]  mie_i;
  logic                 mstatus_mie_i;
  logic                 mstatus_tw_i;
  priv_lvl_e            priv_lvl_i;
  logic [`IRQ_NUM-1:0]  mip_o;
  logic                 irq_ack_o;
  logic [`IRQ_ID_W-1:0] irq_id_o;
  logic                 wb_valid_i;
  instr_word_u          wb_instr_i;
  logic                 wb_err_i;
  logic                 wb_kill_i;
  logic                 ireq_i;
  logic                 ignt_i;
  logic                 irvalid_i;
  logic                 dreq_i;
  logic                 dgnt_i;
  logic                 drvalid_i;
  logic                 wbuf_empty_i;
  logic                 debug_req_i;
  logic                 nmi_i;
  logic                 wu_wfe_i;
  logic                 core_sleep_o;
  logic                 retire_o;

  int unsigned check_count;
  int unsigned err_count;
  int unsigned ack_count;
  int unsigned ack_base;
  int unsigned cycle_count;
  string       test_name;

  // Expected arbiter state advanced on every rising edge
  logic [`IRQ_NUM-1:0]  exp_mip;
  logic                 exp_ack;
  logic [`IRQ_ID_W-1:0] exp_id;
  logic [5:0]           ref_res;
  logic                 model_live = 1'b0;
  logic                 ack_prev = 1'b0;

  irq_sleep_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #10;
      clk_i = ~clk_i;
    end
  end

  // --------------------
  // Reference and checks
  // --------------------
  // Returns {take, id} with priority 31..16 then 11, 3, 7
  function automatic logic [5:0] ref_ack(input logic [31:0] mip, input logic [31:0] mie,
                                         input logic gie, input priv_lvl_e priv);
    logic [31:0] en;
    logic [5:0]  res;
    en  = mip & mie;
    res = '0;
    for (int i = 31; i >= 16; i--) begin
      if (!res[5] && en[i]) res = {1'b1, 5'(i)};
    end
    if (!res[5] && en[11]) res = {1'b1, 5'd11};
    if (!res[5] && en[3]) res = {1'b1, 5'd3};
    if (!res[5] && en[7]) res = {1'b1, 5'd7};
    // M-mode needs MSTATUS.MIE while U-mode takes any enabled line
    if (!((priv == PRIV_M && gie) || priv == PRIV_U)) res[5] = 1'b0;
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  always @(posedge clk_i) begin
    model_live = rst_ni;
    if (!rst_ni) begin
      exp_mip = '0;
      exp_ack = 1'b0;
    end else begin
      ref_res = ref_ack(exp_mip, mie_i, mstatus_mie_i, priv_lvl_i);
      // A pulse in this cycle blocks a grant in the next one
      exp_ack = ref_res[5] && !exp_ack;
      if (exp_ack) exp_id = ref_res[4:0];
      exp_mip = irq_i & `IRQ_VALID_MASK;
    end
  end

  always @(negedge clk_i) begin
    if (model_live) begin
      check_value({test_name, " mip"}, exp_mip, mip_o);
      check_value({test_name, " irq_ack"}, 32'(exp_ack), 32'(irq_ack_o));
      if (exp_ack) begin
        check_value({test_name, " irq_id"}, 32'(exp_id), 32'(irq_id_o));
      end
      if (irq_ack_o && ack_prev) begin
        err_count++;
        $display("Acknowledge stayed high for two cycles in a row");
      end
      ack_prev = irq_ack_o;
      if (irq_ack_o) ack_count++;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic drive_idle();
    irq_i         = '0;
    mie_i         = '0;
    mstatus_mie_i = 1'b0;
    mstatus_tw_i  = 1'b0;
    priv_lvl_i    = PRIV_M;
    wb_valid_i    = 1'b0;
    wb_instr_i.raw = '0;
    wb_err_i      = 1'b0;
    wb_kill_i     = 1'b0;
    ireq_i        = 1'b0;
    ignt_i        = 1'b0;
    irvalid_i     = 1'b0;
    dreq_i        = 1'b0;
    dgnt_i        = 1'b0;
    drvalid_i     = 1'b0;
    wbuf_empty_i  = 1'b1;
    debug_req_i   = 1'b0;
    nmi_i         = 1'b0;
    wu_wfe_i      = 1'b0;
  endtask

  task automatic random_irqs(input priv_lvl_e priv, input logic gie);
    repeat (RAND_CYCLES) begin
      @(negedge clk_i);
      priv_lvl_i    = priv;
      mstatus_mie_i = gie;
      irq_i         = $urandom();
      mie_i         = $urandom() & $urandom();
      // Half the vectors enable only low lines so 11, 3 and 7 can win
      if ($urandom() % 2 == 0) mie_i = mie_i & 32'h0000_0fff;
    end
    @(negedge clk_i);
    drive_idle();
    repeat (3) @(negedge clk_i);
  endtask

  task automatic present_instr(input logic [11:0] funct12);
    wb_instr_i.raw = {funct12, 5'd0, 3'b000, 5'd0, `OPC_SYSTEM};
    wb_valid_i     = 1'b1;
  endtask

  task automatic expect_awake(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_value({test_name, " core_sleep"}, 32'd0, 32'(core_sleep_o));
    end
  endtask

  task automatic enter_sleep(input logic [11:0] funct12);
    drive_idle();
    repeat (2) @(negedge clk_i);
    present_instr(funct12);
    for (int k = 1; k <= `SLEEP_DWELL + 1; k++) begin
      @(negedge clk_i);
      check_value({test_name, " core_sleep"}, 32'(k == `SLEEP_DWELL + 1), 32'(core_sleep_o));
    end
  endtask

  task automatic blocked_wfi(input logic kill, input logic err, input logic user_tw);
    drive_idle();
    repeat (2) @(negedge clk_i);
    wb_kill_i = kill;
    wb_err_i  = err;
    if (user_tw) begin
      priv_lvl_i   = PRIV_U;
      mstatus_tw_i = 1'b1;
    end
    present_instr(`WFI_FUNCT12);
    expect_awake(`SLEEP_DWELL + 4);
  endtask

  // One transaction left open on the chosen bus side before the WFI arrives
  task automatic bus_blocked_wfi(input logic data_side);
    drive_idle();
    @(negedge clk_i);
    dreq_i = data_side;
    dgnt_i = data_side;
    ireq_i = !data_side;
    ignt_i = !data_side;
    @(negedge clk_i);
    dreq_i = 1'b0;
    dgnt_i = 1'b0;
    ireq_i = 1'b0;
    ignt_i = 1'b0;
    present_instr(`WFI_FUNCT12);
    expect_awake(`SLEEP_DWELL + 4);
    drvalid_i = data_side;
    irvalid_i = !data_side;
    @(negedge clk_i);
    drvalid_i = 1'b0;
    irvalid_i = 1'b0;
    check_value({test_name, " core_sleep at response"}, 32'd0, 32'(core_sleep_o));
    @(negedge clk_i);
    check_value({test_name, " core_sleep after response"}, 32'd1, 32'(core_sleep_o));
  endtask

  // Retire is combinational and follows the wake source applied just before
  task automatic check_wake(input logic wakes);
    #1;
    check_value({test_name, " retire"}, 32'(wakes), 32'(retire_o));
    check_value({test_name, " core_sleep before edge"}, 32'd1, 32'(core_sleep_o));
    @(negedge clk_i);
    check_value({test_name, " core_sleep after edge"}, 32'(!wakes), 32'(core_sleep_o));
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    void'($urandom(48));
    test_name = "reset";
    rst_ni    = 1'b0;
    drive_idle();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "arbitration";
    random_irqs(PRIV_M, 1'b1);

    test_name = "mie clear";
    ack_base  = ack_count;
    random_irqs(PRIV_M, 1'b0);
    check_value({test_name, " ack count"}, ack_base, ack_count);

    test_name = "user mode";
    ack_base  = ack_count;
    random_irqs(PRIV_U, 1'b0);
    if (ack_count == ack_base) begin
      err_count++;
      $display("No acknowledge was given in U-mode with enabled lines pending");
    end

    test_name = "sleep entry";
    enter_sleep(`WFI_FUNCT12);
    test_name = "wfi killed";
    blocked_wfi(1'b1, 1'b0, 1'b0);
    test_name = "wfi bus error";
    blocked_wfi(1'b0, 1'b1, 1'b0);
    test_name = "wfi user timeout wait";
    blocked_wfi(1'b0, 1'b0, 1'b1);

    test_name = "blocking data side";
    bus_blocked_wfi(1'b1);
    test_name = "blocking instr side";
    bus_blocked_wfi(1'b0);

    test_name = "wake debug";
    enter_sleep(`WFI_FUNCT12);
    debug_req_i = 1'b1;
    check_wake(1'b1);
    test_name = "wake nmi";
    enter_sleep(`WFI_FUNCT12);
    nmi_i = 1'b1;
    check_wake(1'b1);
    test_name = "wake irq";
    enter_sleep(`WFI_FUNCT12);
    mie_i[16] = 1'b1;
    irq_i[16] = 1'b1;
    // Line reaches mip one edge later
    @(negedge clk_i);
    check_wake(1'b1);
    test_name = "wake wfe";
    enter_sleep(`WFE_FUNCT12);
    wu_wfe_i = 1'b1;
    check_wake(1'b1);
    test_name = "wfi ignores wfe wakeup";
    enter_sleep(`WFI_FUNCT12);
    wu_wfe_i = 1'b1;
    check_wake(1'b0);

    drive_idle();
    repeat (2) @(negedge clk_i);
    $display("Checks: %0d, errors: %0d, acknowledges: %0d", check_count, err_count, ack_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/irq_sleep_pkg.sv
verilog/irq_arbiter.sv
verilog/bus_idle_tracker.sv
verilog/wfi_decode_stage.sv
verilog/sleep_ctrl.sv
verilog/irq_sleep_top.sv
test/tb_irq_sleep.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f project.f \
  --top-module tb_irq_sleep \
  -o sim_tb_irq_sleep

./obj_dir/sim_tb_irq_sleep > sim.log 2>&1
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1
